//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = exec_cluster_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module alu (
    input  logic                    clock,
    input  logic                    reset,
    input  exec_pkg::issue_packet_t is_pack,
    input  logic                    stall,
    input  logic                    rd_in,
    output exec_pkg::fu_packet_t    fu_pack,
    output logic                    data_ready
);

    exec_pkg::rv_inst_u    inst;
    logic [`EXEC_XLEN-1:0] i_imm;
    logic [`EXEC_XLEN-1:0] s_imm;
    logic [`EXEC_XLEN-1:0] b_imm;
    logic [`EXEC_XLEN-1:0] u_imm;
    logic [`EXEC_XLEN-1:0] j_imm;
    logic [`EXEC_XLEN-1:0] opa;
    logic [`EXEC_XLEN-1:0] opb;
    logic [`EXEC_XLEN-1:0] result;
    exec_pkg::fu_packet_t  out_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Immediate decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign inst  = is_pack.inst;
    assign i_imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign s_imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
    assign b_imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign u_imm = {inst.u_fmt.imm_31_12, 12'b0};
    assign j_imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        case (is_pack.opa_select)
            exec_pkg::OPA_IS_RS1: opa = is_pack.rs1_value;
            exec_pkg::OPA_IS_NPC: opa = is_pack.npc;
            exec_pkg::OPA_IS_PC:  opa = is_pack.pc;
            default:              opa = '0;  // Zero operand
        endcase
    end

    always_comb begin
        case (is_pack.opb_select)
            exec_pkg::OPB_IS_RS2:   opb = is_pack.rs2_value;
            exec_pkg::OPB_IS_I_IMM: opb = i_imm;
            exec_pkg::OPB_IS_S_IMM: opb = s_imm;
            exec_pkg::OPB_IS_B_IMM: opb = b_imm;
            exec_pkg::OPB_IS_U_IMM: opb = u_imm;
            exec_pkg::OPB_IS_J_IMM: opb = j_imm;
            default:                opb = '0;
        endcase
    end

    always_comb begin
        case (is_pack.alu_func)
            exec_pkg::ADD:  result = opa + opb;
            exec_pkg::SUB:  result = opa - opb;
            exec_pkg::AND:  result = opa & opb;
            exec_pkg::SLT:  result = {{(`EXEC_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            exec_pkg::SLTU: result = {{(`EXEC_XLEN-1){1'b0}}, opa < opb};
            exec_pkg::OR:   result = opa | opb;
            exec_pkg::XOR:  result = opa ^ opb;
            exec_pkg::SRL:  result = opa >> opb[4:0];
            exec_pkg::SLL:  result = opa << opb[4:0];
            exec_pkg::SRA:  result = $unsigned($signed(opa) >>> opb[4:0]);
            default:        result = '0;
        endcase
    end

    // Valid flag and result both freeze while stalled
    always_ff @(posedge clock) begin
        if (reset) begin
            data_ready <= 1'b0;
        end else if (!stall) begin
            data_ready <= rd_in;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_in && !stall) begin
            out_q <= '{tag: is_pack.tag, result: result, take_conditional: 1'b0};
        end
    end

    assign fu_pack = out_q;

endmodule

`default_nettype wire

//--- cdb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter (
    input  logic                 alu_valid,
    input  exec_pkg::fu_packet_t alu_pack,
    input  logic                 mult_valid,
    input  exec_pkg::fu_packet_t mult_pack,
    output logic                 alu_stall,
    output logic                 mult_grant,
    output logic                 cdb_valid,
    output exec_pkg::fu_packet_t cdb_pack
);

    // Fixed priority to the multiplier
    always_comb begin
        mult_grant = mult_valid;
        alu_stall  = alu_valid && mult_valid;  // ALU holds its result
        cdb_valid  = alu_valid || mult_valid;
        if (mult_valid) begin
            cdb_pack = mult_pack;
        end else begin
            cdb_pack = alu_pack;
        end
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
exec_pkg.sv
alu.sv
mult_cycle_counter.sv
mult_unit.sv
issue_ctrl.sv
cdb_arbiter.sv
exec_cluster.sv
exec_cluster_tb.sv

//--- exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Datapath width
`define EXEC_XLEN       32

// Reorder buffer tag width
`define EXEC_TAG_W      5

// Multiplier iterations per product
`define EXEC_MULT_STEPS 4

`endif

//--- exec_cluster.sv
`timescale 1ns/100ps
`default_nettype none

module exec_cluster (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  exec_pkg::issue_packet_t issue_pack,
    output logic                    issue_ready,
    output logic                    cdb_valid,
    output exec_pkg::fu_packet_t    cdb_pack
);

    logic                 alu_start;
    logic                 alu_stall;
    logic                 alu_valid;
    exec_pkg::fu_packet_t alu_pack;
    logic                 mult_load;
    logic                 mult_step;
    exec_pkg::fu_packet_t mult_pack;
    logic                 count_load;
    logic                 count_en;
    logic                 count_last;
    logic                 mult_valid;
    logic                 mult_grant;

    issue_ctrl issue_ctrl_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .is_pack     (issue_pack),
        .issue_ready (issue_ready),
        .alu_stall   (alu_stall),
        .alu_start   (alu_start),
        .mult_load   (mult_load),
        .mult_step   (mult_step),
        .count_load  (count_load),
        .count_en    (count_en),
        .count_last  (count_last),
        .mult_valid  (mult_valid),
        .mult_grant  (mult_grant)
    );

    alu alu_i (
        .clock      (clock),
        .reset      (reset),
        .is_pack    (issue_pack),
        .stall      (alu_stall),
        .rd_in      (alu_start),
        .fu_pack    (alu_pack),
        .data_ready (alu_valid)
    );

    mult_unit mult_unit_i (
        .clock     (clock),
        .reset     (reset),
        .is_pack   (issue_pack),
        .mult_load (mult_load),
        .mult_step (mult_step),
        .mult_pack (mult_pack)
    );

    mult_cycle_counter mult_cycle_counter_i (
        .clock      (clock),
        .reset      (reset),
        .count_load (count_load),
        .count_en   (count_en),
        .count_last (count_last)
    );

    cdb_arbiter cdb_arbiter_i (
        .alu_valid  (alu_valid),
        .alu_pack   (alu_pack),
        .mult_valid (mult_valid),
        .mult_pack  (mult_pack),
        .alu_stall  (alu_stall),
        .mult_grant (mult_grant),
        .cdb_valid  (cdb_valid),
        .cdb_pack   (cdb_pack)
    );

endmodule

`default_nettype wire

//--- exec_cluster_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module exec_cluster_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_PKTS   = 320;
    localparam int NUM_COMBOS = 240;  // 10 functions x 4 A sources x 6 B sources
    localparam int NUM_TAGS   = 1 << `EXEC_TAG_W;

    logic                    clock;
    logic                    reset;
    logic                    issue_valid;
    exec_pkg::issue_packet_t issue_pack;
    logic                    issue_ready;
    logic                    cdb_valid;
    exec_pkg::fu_packet_t    cdb_pack;

    logic [31:0]            lcg_state;
    logic [`EXEC_XLEN-1:0]  exp_result [0:NUM_TAGS-1];
    logic [NUM_TAGS-1:0]    tag_pending;
    logic [NUM_TAGS-1:0]    tag_is_mult;
    logic                   mult_busy;
    logic                   alu_due;
    logic [`EXEC_TAG_W-1:0] alu_due_tag;
    int errors      = 0;
    int checks      = 0;
    int accepted    = 0;
    int completed   = 0;
    int blocked_cnt = 0;
    int stall_cnt   = 0;

    exec_cluster exec_cluster_i (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_pack  (issue_pack),
        .issue_ready (issue_ready),
        .cdb_valid   (cdb_valid),
        .cdb_pack    (cdb_pack)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #((NUM_PKTS * (`EXEC_MULT_STEPS + 6) + 20) * CLK_PERIOD);
        $display("Timeout: not every packet completed in the allotted time");
        $display("*** FAILED ***");
        $finish;
    end

    task automatic log_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic log_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random source and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n;  // Upper bits only
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic logic [31:0] model_mult(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] full;
        full = {32'd0, a} * {32'd0, b};
        return full[31:0];
    endfunction

    function automatic logic [31:0] model_alu(input exec_pkg::issue_packet_t p);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        w = p.inst;
        case (p.opa_select)
            exec_pkg::OPA_IS_RS1: a = p.rs1_value;
            exec_pkg::OPA_IS_NPC: a = p.npc;
            exec_pkg::OPA_IS_PC:  a = p.pc;
            default:              a = 32'd0;
        endcase
        case (p.opb_select)
            exec_pkg::OPB_IS_RS2:   b = p.rs2_value;
            exec_pkg::OPB_IS_I_IMM: b = {{20{w[31]}}, w[31:20]};
            exec_pkg::OPB_IS_S_IMM: b = {{20{w[31]}}, w[31:25], w[11:7]};
            exec_pkg::OPB_IS_B_IMM: b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            exec_pkg::OPB_IS_U_IMM: b = {w[31:12], 12'd0};
            exec_pkg::OPB_IS_J_IMM: b = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:                b = 32'd0;
        endcase
        case (p.alu_func)
            exec_pkg::ADD:  return a + b;
            exec_pkg::SUB:  return a - b;
            exec_pkg::AND:  return a & b;
            exec_pkg::SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            exec_pkg::SLTU: return {31'd0, a < b};
            exec_pkg::OR:   return a | b;
            exec_pkg::XOR:  return a ^ b;
            exec_pkg::SRL:  return a >> b[4:0];
            exec_pkg::SLL:  return a << b[4:0];
            exec_pkg::SRA:  return a[31] ? ~(~a >> b[4:0]) : a >> b[4:0];
            default:        return 32'd0;
        endcase
    endfunction

    function automatic exec_pkg::issue_packet_t make_packet(input logic [`EXEC_TAG_W-1:0] tag,
                                                             input logic mult, input int combo);
        exec_pkg::issue_packet_t p;
        p.tag        = tag;
        p.fu_sel     = mult ? exec_pkg::FU_MULT : exec_pkg::FU_ALU;
        p.alu_func   = exec_pkg::alu_func_e'(4'(combo % 10));
        p.opa_select = exec_pkg::opa_sel_e'(2'((combo / 10) % 4));
        p.opb_select = exec_pkg::opb_sel_e'(3'(combo / 40));
        p.inst       = rand_word();
        p.pc         = rand_word() & ~32'd3;
        p.npc        = p.pc + 32'd4;
        p.rs1_value  = rand_word();
        p.rs2_value  = rand_word();
        return p;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scoreboard sampled mid-cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clock) begin
        logic [`EXEC_TAG_W-1:0] t;
        logic                   mult_beat;
        if (reset) begin
            tag_pending = '0;
            mult_busy   = 1'b0;
            alu_due     = 1'b0;
        end else begin
            t         = cdb_pack.tag;
            mult_beat = cdb_valid && tag_pending[t] && tag_is_mult[t];
            if (issue_valid && issue_pack.fu_sel == exec_pkg::FU_MULT && mult_busy) begin
                blocked_cnt++;
                assert (!issue_ready) else log_error("issue_ready high for a multiply while busy");
            end
            if (alu_due && mult_beat) begin
                stall_cnt++;  // ALU result parked behind the multiply
            end else if (alu_due) begin
                alu_due = 1'b0;
                assert (cdb_valid) else log_error("ALU result missing one cycle after issue");
                assert (!cdb_valid || t == alu_due_tag)
                    else log_mismatch("cdb_pack.tag", 32'(alu_due_tag), 32'(t));
            end
            if (cdb_valid) begin
                checks++;
                assert (tag_pending[t]) else log_error("cdb carried a tag that was not outstanding");
                if (tag_pending[t]) begin
                    assert (cdb_pack.result == exp_result[t])
                        else log_mismatch("cdb_pack.result", exp_result[t], cdb_pack.result);
                    assert (!cdb_pack.take_conditional)
                        else log_mismatch("cdb_pack.take_conditional", 32'd0, 32'd1);
                    tag_pending[t] = 1'b0;
                    completed++;
                end
                if (mult_beat) begin
                    mult_busy = 1'b0;
                end
            end
            if (issue_valid && issue_ready) begin  // Accepted at the coming edge
                t = issue_pack.tag;
                tag_pending[t] = 1'b1;
                tag_is_mult[t] = (issue_pack.fu_sel == exec_pkg::FU_MULT);
                accepted++;
                if (tag_is_mult[t]) begin
                    exp_result[t] = model_mult(issue_pack.rs1_value, issue_pack.rs2_value);
                    mult_busy     = 1'b1;
                end else begin
                    exp_result[t] = model_alu(issue_pack);
                    alu_due       = 1'b1;
                    alu_due_tag   = t;
                end
            end
        end
    end

    initial begin
        int                      alu_cnt;
        logic                    mult;
        logic [`EXEC_TAG_W-1:0]  next_tag;
        exec_pkg::issue_packet_t pkt;
        lcg_state   = 32'd47;
        alu_cnt     = 0;
        next_tag    = '0;
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_pack  = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (!cdb_valid) else log_error("cdb_valid high after reset");
        assert (issue_ready) else log_error("issue_ready low after reset");
        for (int k = 0; k < NUM_PKTS; k++) begin
            // Burst of multiplies while leaving enough ALU packets for every combination
            mult = ((k >= 100 && k < 106) || rand_below(4) == 0)
                   && (NUM_PKTS - k > NUM_COMBOS - alu_cnt);
            while (tag_pending[next_tag]) @(negedge clock);
            pkt = make_packet(next_tag, mult, mult ? rand_below(NUM_COMBOS) : alu_cnt % NUM_COMBOS);
            next_tag++;
            if (!mult) begin
                alu_cnt++;
            end
            if (rand_below(4) == 0) begin
                @(posedge clock);
                issue_valid <= 1'b0;  // Idle cycle
            end
            @(posedge clock);
            issue_valid <= 1'b1;
            issue_pack  <= pkt;
            @(negedge clock);
            while (!issue_ready) @(negedge clock);
        end
        @(posedge clock);
        issue_valid <= 1'b0;
        while (completed != accepted) @(negedge clock);
        repeat (4) @(negedge clock);
        assert (blocked_cnt > 0) else log_error("no multiply met a busy multiplier");
        assert (stall_cnt > 0) else log_error("no ALU and multiplier collision occurred");
        $display("errors=%0d checks=%0d accepted=%0d completed=%0d mult_blocked=%0d alu_stalls=%0d",
                 errors, checks, accepted, completed, blocked_cnt, stall_cnt);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exec_pkg.sv
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode selects
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {OPA_IS_RS1, OPA_IS_NPC, OPA_IS_PC, OPA_IS_ZERO} opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM,
        OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
    } opb_sel_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, SLT, SLTU, OR, XOR, SRL, SLL, SRA
    } alu_func_e;

    typedef enum logic {FU_ALU, FU_MULT} fu_sel_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RV32 instruction formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef union packed {
        struct packed {
            logic [6:0]  funct7;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0]  imm_11_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_4_0;
            logic [6:0]  opcode;
        } s_fmt;
        struct packed {
            logic        imm_12;
            logic [5:0]  imm_10_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm_4_1;
            logic        imm_11;
            logic [6:0]  opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic        imm_20;
            logic [9:0]  imm_10_1;
            logic        imm_11;
            logic [7:0]  imm_19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j_fmt;
    } rv_inst_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue and completion packets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [`EXEC_TAG_W-1:0] tag;
        fu_sel_e                fu_sel;
        alu_func_e              alu_func;
        opa_sel_e               opa_select;
        opb_sel_e               opb_select;
        rv_inst_u               inst;
        logic [`EXEC_XLEN-1:0]  pc;
        logic [`EXEC_XLEN-1:0]  npc;
        logic [`EXEC_XLEN-1:0]  rs1_value;
        logic [`EXEC_XLEN-1:0]  rs2_value;
    } issue_packet_t;

    typedef struct packed {
        logic [`EXEC_TAG_W-1:0] tag;
        logic [`EXEC_XLEN-1:0]  result;
        logic                   take_conditional;  // Never set here
    } fu_packet_t;

endpackage

`default_nettype wire

//--- issue_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module issue_ctrl (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue_valid,
    input  exec_pkg::issue_packet_t is_pack,
    output logic                    issue_ready,
    input  logic                    alu_stall,
    output logic                    alu_start,
    output logic                    mult_load,
    output logic                    mult_step,
    output logic                    count_load,
    output logic                    count_en,
    input  logic                    count_last,
    output logic                    mult_valid,
    input  logic                    mult_grant
);

    typedef enum logic [1:0] {MULT_IDLE, MULT_RUN, MULT_DONE} mult_state_e;

    mult_state_e state;
    mult_state_e state_next;
    logic        is_mult;
    logic        accept;

    assign is_mult = (is_pack.fu_sel == exec_pkg::FU_MULT);

    // Hold off while the ALU result is parked or a multiply would collide
    assign issue_ready = !alu_stall && !(is_mult && (state != MULT_IDLE));
    assign accept      = issue_valid && issue_ready;

    assign alu_start  = accept && !is_mult;
    assign mult_load  = accept && is_mult;
    assign count_load = mult_load;
    assign mult_step  = (state == MULT_RUN);
    assign count_en   = mult_step;
    assign mult_valid = (state == MULT_DONE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multiplier sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_next = state;
        case (state)
            MULT_IDLE: begin
                if (mult_load) begin
                    state_next = MULT_RUN;
                end
            end
            MULT_RUN: begin
                if (count_last) begin
                    state_next = MULT_DONE;  // Final step taken this cycle
                end
            end
            MULT_DONE: begin
                if (mult_grant) begin
                    state_next = MULT_IDLE;
                end
            end
            default: state_next = MULT_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= MULT_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

//--- mult_cycle_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module mult_cycle_counter (
    input  logic clock,
    input  logic reset,
    input  logic count_load,
    input  logic count_en,
    output logic count_last
);

    localparam int CNT_W = $clog2(`EXEC_MULT_STEPS);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (count_load) begin
            count <= CNT_W'(`EXEC_MULT_STEPS - 1);  // Iterations left after this one
        end else if (count_en && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    assign count_last = (count == '0);

endmodule

`default_nettype wire

//--- mult_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_cfg.svh"

module mult_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  exec_pkg::issue_packet_t is_pack,
    input  logic                    mult_load,
    input  logic                    mult_step,
    output exec_pkg::fu_packet_t    mult_pack
);

    localparam int DIGIT_W = `EXEC_XLEN / `EXEC_MULT_STEPS;  // Multiplier bits per step

    logic [`EXEC_XLEN-1:0]  mcand;
    logic [`EXEC_XLEN-1:0]  mplier;
    logic [`EXEC_XLEN-1:0]  acc;
    logic [`EXEC_XLEN-1:0]  partial;
    logic [`EXEC_TAG_W-1:0] tag_q;

    // Multiplicand times the low multiplier digit
    assign partial = mcand * {{(`EXEC_XLEN-DIGIT_W){1'b0}}, mplier[DIGIT_W-1:0]};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand shift registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clock) begin
        if (mult_load) begin
            mcand  <= is_pack.rs1_value;
            mplier <= is_pack.rs2_value;
            tag_q  <= is_pack.tag;
        end else if (mult_step) begin
            mcand  <= mcand << DIGIT_W;
            mplier <= mplier >> DIGIT_W;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            acc <= '0;
        end else if (mult_load) begin
            acc <= '0;
        end else if (mult_step) begin
            acc <= acc + partial;  // Low word only
        end
    end

    assign mult_pack = '{tag: tag_q, result: acc, take_conditional: 1'b0};

endmodule

`default_nettype wire
